// File: board_glue_top.f
src/board_glue_pkg.sv
src/pad_mux.sv
src/rtc_divider.sv
src/fan_pwm.sv
src/board_ctrl.sv
src/board_glue_top.sv
bench/board_glue_asserts.sv
bench/board_glue_tb.sv

// File: bench/board_glue_tb.sv
`timescale 1ns/1ps

module board_glue_tb
  import board_glue_pkg::*;
();

  localparam int CLK_PERIOD  = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int FAN_PERIOD  = FAN_PRESCALE * (2 ** FAN_SET_W);
  // Upper estimate of the test length in cycles
  localparam int TEST_CYCLES    = 900;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 200;

  logic                 soc_clk;
  logic                 rst_n;
  logic                 testmode_i;
  cfg_req_t             cfg_req [NUM_CFG];
  cfg_rsp_t             cfg_rsp [NUM_CFG];
  logic                 soc_rst_no;
  logic                 rtc_o;
  logic [FAN_SET_W-1:0] fan_sw_i;
  logic                 fan_pwm_o;
  spi_host_t            spi_host_i;
  logic [SPI_SD_N-1:0]  spi_sd_o;
  sd_pins_t             sd_pins_o;
  logic                 sd_dat0_i;
  i2c_host_t            i2c_host_i;
  i2c_pads_t            i2c_pads_o;
  logic                 i2c_sda_i;
  logic                 i2c_scl_i;
  logic                 i2c_sda_o;
  logic                 i2c_scl_o;

  logic [15:0] lfsr_q;
  int          err_cnt;
  int          check_cnt;
  int          cycle_cnt;

  board_glue_top dut0 (
    .dram_cfg_req_i ( cfg_req[0] ),
    .fll_cfg_req_i  ( cfg_req[1] ),
    .pad_cfg_req_i  ( cfg_req[2] ),
    .dram_cfg_rsp_o ( cfg_rsp[0] ),
    .fll_cfg_rsp_o  ( cfg_rsp[1] ),
    .pad_cfg_rsp_o  ( cfg_rsp[2] ),
    .*
  );

  initial begin
    soc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) soc_clk = ~soc_clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge soc_clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, a test never finished", cycle_cnt);
    $display("Checks failed");
    $finish;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic step();
    @(posedge soc_clk);
    #DRIVE_DELAY;
  endtask

  task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Fail %s: got %0h, expected %0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report(input string test, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("%s: ok", test);
    end else begin
      $display("%s: %0d errors", test, err_cnt - errs_before);
    end
  endtask

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic reset_sequence();
    int errs;
    errs = err_cnt;
    rst_n = 1'b0;
    repeat (3) step();
    check_hex("soc_rst_no", soc_rst_no, 0);
    rst_n = 1'b1;
    for (int k = 1; k <= RESET_HOLD + 2; k++) begin
      step();
      check_hex("soc_rst_no", soc_rst_no, k >= RESET_HOLD);
    end
    // Test mode passes the board reset straight through
    testmode_i = 1'b1;
    rst_n = 1'b0;
    #1;
    check_hex("soc_rst_no", soc_rst_no, 0);
    step();
    rst_n = 1'b1;
    #1;
    check_hex("soc_rst_no", soc_rst_no, 1);
    repeat (RESET_HOLD + 1) step();
    testmode_i = 1'b0;
    #1;
    check_hex("soc_rst_no", soc_rst_no, 1);
    report("reset sequence", errs);
  endtask

  task automatic config_errors();
    int          errs;
    logic [31:0] r;
    cfg_rsp_t    exp;
    errs = err_cnt;
    step();
    for (int p = 0; p < NUM_CFG; p++) begin
      for (int w = 0; w < 2; w++) begin
        r = take_bits(16);
        cfg_req[p].addr  = {r[15:0], take_bits(32)};
        cfg_req[p].wdata = take_bits(32);
        r = take_bits(4);
        cfg_req[p].wstrb = r[3:0];
        cfg_req[p].write = w[0];
        cfg_req[p].valid = 1'b1;
        #1;
        for (int q = 0; q < NUM_CFG; q++) begin
          exp = (q == p) ? {1'b1, 1'b1, CFG_ERR_VAL} : '0;
          check_hex($sformatf("cfg_rsp[%0d]", q), cfg_rsp[q], exp);
        end
        step();
        cfg_req[p] = '0;
      end
    end
    #1;
    for (int q = 0; q < NUM_CFG; q++) begin
      check_hex($sformatf("cfg_rsp[%0d]", q), cfg_rsp[q], 0);
    end
    report("config errors", errs);
  endtask

  task automatic rtc_clock();
    int errs;
    int waited;
    errs = err_cnt;
    step();
    rst_n = 1'b0;
    step();
    rst_n = 1'b1;
    waited = 0;
    while (!soc_rst_no && waited < 4 * RESET_HOLD) begin
      step();
      waited++;
    end
    check_cnt++;
    if (!soc_rst_no) begin
      $display("SoC reset never released before the RTC test");
      err_cnt++;
    end
    // Level after edge k counted from the release edge
    for (int k = 1; k <= 6 * RTC_HALF_PERIOD; k++) begin
      step();
      check_hex("rtc_o", rtc_o, (k / RTC_HALF_PERIOD) % 2);
    end
    report("rtc clock", errs);
  endtask

  task automatic fan_duty();
    int errs;
    int high_cnt;
    int settings [3];
    errs = err_cnt;
    settings = '{0, 5, 15};
    foreach (settings[i]) begin
      fan_sw_i = settings[i][FAN_SET_W-1:0];
      repeat (FAN_PERIOD) step();
      high_cnt = 0;
      repeat (FAN_PERIOD) begin
        step();
        if (fan_pwm_o) begin
          high_cnt++;
        end
      end
      check_hex("fan_pwm_o high cycles", high_cnt, FAN_PRESCALE * settings[i]);
    end
    report("fan duty", errs);
  endtask

  task automatic pad_mapping();
    int          errs;
    logic [31:0] r;
    sd_pins_t    exp_sd;
    errs = err_cnt;
    repeat (8) begin
      r = take_bits(20);
      {spi_host_i, i2c_host_i, sd_dat0_i, i2c_sda_i, i2c_scl_i} = r[19:0];
      #1;
      // A pin without its enable reads high
      exp_sd.sclk = spi_host_i.sck | ~spi_host_i.sck_en;
      exp_sd.cs   = spi_host_i.csb[0] | ~spi_host_i.csb_en[0];
      exp_sd.cmd  = spi_host_i.sd_o[0] | ~spi_host_i.sd_en[0];
      check_hex("sd_pins_o", sd_pins_o, exp_sd);
      check_hex("spi_sd_o", spi_sd_o, {sd_dat0_i, 1'b0});
      check_hex("i2c_pads_o", i2c_pads_o, {i2c_host_i.sda_o, i2c_host_i.sda_en,
                                           i2c_host_i.scl_o, i2c_host_i.scl_en});
      check_hex("i2c_sda_o", i2c_sda_o, i2c_sda_i);
      check_hex("i2c_scl_o", i2c_scl_o, i2c_scl_i);
      step();
    end
    report("pad mapping", errs);
  endtask

  initial begin
    lfsr_q     = 16'd17;
    err_cnt    = 0;
    check_cnt  = 0;
    rst_n      = 1'b0;
    testmode_i = 1'b0;
    foreach (cfg_req[i]) begin
      cfg_req[i] = '0;
    end
    fan_sw_i   = '0;
    spi_host_i = '0;
    sd_dat0_i  = 1'b0;
    i2c_host_i = '0;
    i2c_sda_i  = 1'b1;
    i2c_scl_i  = 1'b1;
    reset_sequence();
    config_errors();
    rtc_clock();
    fan_duty();
    pad_mapping();
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: bench/board_glue_asserts.sv
`timescale 1ns/1ps

module board_glue_asserts
  import board_glue_pkg::*;
(
  input logic      soc_clk,
  input logic      rst_n,
  input cfg_req_t  dram_cfg_req_i,
  input cfg_req_t  fll_cfg_req_i,
  input cfg_req_t  pad_cfg_req_i,
  input cfg_rsp_t  dram_cfg_rsp_o,
  input cfg_rsp_t  fll_cfg_rsp_o,
  input cfg_rsp_t  pad_cfg_rsp_o,
  input logic      soc_rst_no,
  input logic      rtc_o,
  input spi_host_t spi_host_i,
  input sd_pins_t  sd_pins_o
);

  // Every request is answered in the cycle it is presented
  ready_is_valid: assert property (@(posedge soc_clk) disable iff (!rst_n)
    {dram_cfg_rsp_o.ready, fll_cfg_rsp_o.ready, pad_cfg_rsp_o.ready} ==
    {dram_cfg_req_i.valid, fll_cfg_req_i.valid, pad_cfg_req_i.valid})
    else $error("config ready differs from request valid");

  rtc_low_in_reset: assert property (@(posedge soc_clk) !soc_rst_no |-> !rtc_o)
    else $error("rtc_o high while the SoC is in reset");

  // Idle SD clock sits high
  sclk_idle_high: assert property (@(posedge soc_clk) !spi_host_i.sck_en |-> sd_pins_o.sclk)
    else $error("SD clock low while sck_en is low");

endmodule

bind board_glue_top board_glue_asserts asserts0 (.*);

// File: src/board_glue_top.sv
`timescale 1ns/1ps

module board_glue_top
  import board_glue_pkg::*;
(
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  logic                 testmode_i,

  // Unused config register ports of the SoC
  input  cfg_req_t             dram_cfg_req_i,
  input  cfg_req_t             fll_cfg_req_i,
  input  cfg_req_t             pad_cfg_req_i,
  output cfg_rsp_t             dram_cfg_rsp_o,
  output cfg_rsp_t             fll_cfg_rsp_o,
  output cfg_rsp_t             pad_cfg_rsp_o,

  output logic                 soc_rst_no,
  output logic                 rtc_o,

  input  logic [FAN_SET_W-1:0] fan_sw_i,
  output logic                 fan_pwm_o,

  // SD card over the SoC SPI host
  input  spi_host_t            spi_host_i,
  output logic [SPI_SD_N-1:0]  spi_sd_o,
  output sd_pins_t             sd_pins_o,
  input  logic                 sd_dat0_i,

  // I2C pad controls, tristate lives on the board
  input  i2c_host_t            i2c_host_i,
  output i2c_pads_t            i2c_pads_o,
  input  logic                 i2c_sda_i,
  input  logic                 i2c_scl_i,
  output logic                 i2c_sda_o,
  output logic                 i2c_scl_o
);

  logic     soc_rst_n;
  cfg_req_t cfg_req [NUM_CFG];
  cfg_rsp_t cfg_rsp [NUM_CFG];

  // Port order is dram, fll, pad
  assign cfg_req[0] = dram_cfg_req_i;
  assign cfg_req[1] = fll_cfg_req_i;
  assign cfg_req[2] = pad_cfg_req_i;

  assign dram_cfg_rsp_o = cfg_rsp[0];
  assign fll_cfg_rsp_o  = cfg_rsp[1];
  assign pad_cfg_rsp_o  = cfg_rsp[2];

  assign soc_rst_no = soc_rst_n;

  //////////////////////////////
  // Reset and config errors
  //////////////////////////////

  board_ctrl i_board_ctrl (
    .soc_clk    ( soc_clk    ),
    .rst_n      ( rst_n      ),
    .testmode_i ( testmode_i ),
    .cfg_req_i  ( cfg_req    ),
    .soc_rst_no ( soc_rst_n  ),
    .cfg_rsp_o  ( cfg_rsp    )
  );

  //////////////////////////////
  // Clocks and fan
  //////////////////////////////

  rtc_divider i_rtc_divider (
    .soc_clk ( soc_clk   ),
    .rst_n   ( soc_rst_n ),
    .rtc_o   ( rtc_o     )
  );

  fan_pwm i_fan_pwm (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( soc_rst_n ),
    .setting_i ( fan_sw_i  ),
    .pwm_o     ( fan_pwm_o )
  );

  //////////////////////////////
  // Pads
  //////////////////////////////

  pad_mux i_pad_mux (
    .spi_i     ( spi_host_i ),
    .sd_dat0_i ( sd_dat0_i  ),
    .i2c_i     ( i2c_host_i ),
    .sda_pad_i ( i2c_sda_i  ),
    .scl_pad_i ( i2c_scl_i  ),
    .sd_o      ( sd_pins_o  ),
    .spi_sd_o  ( spi_sd_o   ),
    .i2c_o     ( i2c_pads_o ),
    .sda_o     ( i2c_sda_o  ),
    .scl_o     ( i2c_scl_o  )
  );

endmodule

// File: src/board_ctrl.sv
`timescale 1ns/1ps

module board_ctrl
  import board_glue_pkg::*;
(
  input  logic     soc_clk,
  input  logic     rst_n,
  input  logic     testmode_i,
  input  cfg_req_t cfg_req_i [NUM_CFG],
  output logic     soc_rst_no,
  output cfg_rsp_t cfg_rsp_o [NUM_CFG]
);

  //////////////////////////////
  // Reset sequencer
  //////////////////////////////

  logic [HOLD_CNT_W-1:0] hold_cnt;
  logic                  soc_rst_q;

  // Release lands on the RESET_HOLD-th edge after rst_n rises
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_cnt  <= '0;
      soc_rst_q <= 1'b0;
    end else if (hold_cnt == HOLD_CNT_W'(RESET_HOLD - 1)) begin
      soc_rst_q <= 1'b1;
    end else begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // Test mode hands the board reset straight through
  assign soc_rst_no = testmode_i ? rst_n : soc_rst_q;

  //////////////////////////////
  // Config error responder
  //////////////////////////////

  // Each request completes in its own cycle, no back-pressure.
  // Reads and writes alike are refused, write data is dropped
  always_comb begin
    for (int i = 0; i < NUM_CFG; i++) begin
      cfg_rsp_o[i].ready = cfg_req_i[i].valid;
      cfg_rsp_o[i].error = cfg_req_i[i].valid;
      if (cfg_req_i[i].valid) begin
        cfg_rsp_o[i].rdata = CFG_ERR_VAL;
      end else begin
        cfg_rsp_o[i].rdata = '0;
      end
    end
  end

endmodule

// File: src/fan_pwm.sv
`timescale 1ns/1ps

module fan_pwm
  import board_glue_pkg::*;
(
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  logic [FAN_SET_W-1:0] setting_i,
  output logic                 pwm_o
);

  logic [FAN_PRE_W-1:0] pre_cnt;
  logic [FAN_SET_W-1:0] slot_cnt;
  logic [FAN_SET_W-1:0] setting_q;
  logic                 slot_end;
  logic                 period_end;

  assign slot_end   = (pre_cnt == FAN_PRE_W'(FAN_PRESCALE - 1));
  assign period_end = slot_end && (slot_cnt == '1);

  // Prescaler, FAN_PRESCALE cycles per slot
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_cnt <= '0;
    end else if (slot_end) begin
      pre_cnt <= '0;
    end else begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

  // Slot index wraps on its own after the last slot
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_cnt <= '0;
    end else if (slot_end) begin
      slot_cnt <= slot_cnt + 1'b1;
    end
  end

  // Setting only changes between periods, keeps the duty clean
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      setting_q <= '0;
    end else if (period_end) begin
      setting_q <= setting_i;
    end
  end

  // High for the first setting_q slots, zero means always off
  assign pwm_o = (slot_cnt < setting_q);

endmodule

// File: src/rtc_divider.sv
`timescale 1ns/1ps

module rtc_divider
  import board_glue_pkg::*;
(
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  logic [RTC_CNT_W-1:0] half_cnt;
  logic                 rtc_q;
  logic                 half_wrap;

  assign half_wrap = (half_cnt == RTC_CNT_W'(RTC_HALF_PERIOD - 1));

  // Level flips once per half period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      half_cnt <= '0;
      rtc_q    <= 1'b0;
    end else if (half_wrap) begin
      half_cnt <= '0;
      rtc_q    <= ~rtc_q;
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  assign rtc_o = rtc_q;

endmodule

// File: src/pad_mux.sv
`timescale 1ns/1ps

module pad_mux
  import board_glue_pkg::*;
(
  input  spi_host_t           spi_i,
  input  logic                sd_dat0_i,
  input  i2c_host_t           i2c_i,
  input  logic                sda_pad_i,
  input  logic                scl_pad_i,
  output sd_pins_t            sd_o,
  output logic [SPI_SD_N-1:0] spi_sd_o,
  output i2c_pads_t           i2c_o,
  output logic                sda_o,
  output logic                scl_o
);

  //////////////////////////////
  // SPI to SD card
  //////////////////////////////

  // Idle level of every SD pin is high
  assign sd_o.sclk = spi_i.sck_en    ? spi_i.sck     : 1'b1;
  assign sd_o.cs   = spi_i.csb_en[0] ? spi_i.csb[0]  : 1'b1;
  assign sd_o.cmd  = spi_i.sd_en[0]  ? spi_i.sd_o[0] : 1'b1;

  // MISO arrives on DAT0, other SoC inputs held low
  always_comb begin
    spi_sd_o    = '0;
    spi_sd_o[1] = sd_dat0_i;
  end

  //////////////////////////////
  // I2C open drain
  //////////////////////////////

  assign i2c_o.sda_o  = i2c_i.sda_o;
  assign i2c_o.sda_oe = i2c_i.sda_en;
  assign i2c_o.scl_o  = i2c_i.scl_o;
  assign i2c_o.scl_oe = i2c_i.scl_en;

  // Pad levels back to the SoC
  assign sda_o = sda_pad_i;
  assign scl_o = scl_pad_i;

endmodule

// File: src/board_glue_pkg.sv
package board_glue_pkg;

  // Config register bus
  localparam int CFG_ADDR_W = 48;
  localparam int CFG_DATA_W = 32;
  localparam int NUM_CFG    = 3;
  localparam logic [CFG_DATA_W-1:0] CFG_ERR_VAL = 32'hBADCAB1E;

  // SoC reset hold after board reset release
  localparam int RESET_HOLD = 4;
  localparam int HOLD_CNT_W = $clog2(RESET_HOLD);

  // RTC square wave, period of 2 half periods
  localparam int RTC_HALF_PERIOD = 25;
  localparam int RTC_CNT_W       = $clog2(RTC_HALF_PERIOD);

  // Fan PWM, 2**FAN_SET_W slots per period
  localparam int FAN_SET_W    = 4;
  localparam int FAN_PRESCALE = 4;
  localparam int FAN_PRE_W    = $clog2(FAN_PRESCALE);

  // SPI host widths
  localparam int SPI_CS_N = 2;
  localparam int SPI_SD_N = 4;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [CFG_ADDR_W-1:0] addr;
    logic [CFG_DATA_W-1:0] wdata;
    logic [3:0]            wstrb;
  } cfg_req_t;

  typedef struct packed {
    logic                  ready;
    logic                  error;
    logic [CFG_DATA_W-1:0] rdata;
  } cfg_rsp_t;

  typedef struct packed {
    logic                sck;
    logic                sck_en;
    logic [SPI_CS_N-1:0] csb;
    logic [SPI_CS_N-1:0] csb_en;
    logic [SPI_SD_N-1:0] sd_o;
    logic [SPI_SD_N-1:0] sd_en;
  } spi_host_t;

  // SD card pins in SPI mode, cs drives DAT3
  typedef struct packed {
    logic sclk;
    logic cs;
    logic cmd;
  } sd_pins_t;

  typedef struct packed {
    logic sda_o;
    logic sda_en;
    logic scl_o;
    logic scl_en;
  } i2c_host_t;

  typedef struct packed {
    logic sda_o;
    logic sda_oe;
    logic scl_o;
    logic scl_oe;
  } i2c_pads_t;

endpackage
